// File: axi_read/axi_read_slave.sv
// AXI4 read channel slave
`default_nettype none

module axi_read_slave (
   input  wire                          clk,
   input  wire                          rst,
   // read address
   input  wire axi_mem_pkg::addr_t      araddr,
   input  wire axi_mem_pkg::len_t       arlen,
   input  wire axi_mem_pkg::size_t      arsize,
   input  wire axi_mem_pkg::burst_t     arburst,
   input  wire                          arvalid,
   output logic                         arready,
   // read data
   output axi_mem_pkg::data_t           rdata,
   output axi_mem_pkg::resp_t           rresp,
   output logic                         rlast,
   output logic                         rvalid,
   input  wire                          rready,
   // address generator
   output logic                         ag_load,
   output logic                         ag_advance,
   input  wire axi_mem_pkg::addr_t      ag_addr,
   input  wire axi_mem_pkg::addr_t      ag_next_addr,
   // memory read port
   output axi_mem_pkg::word_idx_t       mem_raddr,
   input  wire axi_mem_pkg::data_t      mem_rdata
);

   typedef enum logic [1:0] {
      st_idle,
      st_fetch,
      st_send
   } state_t;

   state_t            state;
   axi_mem_pkg::len_t beat_cnt;
   axi_mem_pkg::len_t burst_len;
   logic              err;
   logic              ar_fire;
   logic              r_fire;
   logic              last_beat;

   assign ar_fire   = arvalid && arready;
   assign r_fire    = rvalid && rready;
   assign last_beat = beat_cnt == burst_len;

   assign arready = state == st_idle;
   assign rvalid  = state == st_send;
   assign rlast   = rvalid && last_beat;
   assign rresp   = err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
   assign rdata   = err ? '0 : mem_rdata;  // error bursts return zeros

   assign ag_load    = ar_fire;
   assign ag_advance = r_fire;

   // a taken beat fetches the following word for the next cycle
   // a stalled beat reads its own word again
   always_comb begin
      if (r_fire) begin
         mem_raddr = ag_next_addr[axi_mem_pkg::WORD_MSB:axi_mem_pkg::WORD_LSB];
      end else begin
         mem_raddr = ag_addr[axi_mem_pkg::WORD_MSB:axi_mem_pkg::WORD_LSB];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= st_idle;
         beat_cnt <= '0;
         err      <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (ar_fire) begin
                  state    <= st_fetch;
                  beat_cnt <= '0;
                  err      <= arburst == axi_mem_pkg::BURST_RSVD;
               end
            end
            st_fetch: state <= st_send;  // first word in flight
            st_send: begin
               if (r_fire) begin
                  beat_cnt <= beat_cnt + axi_mem_pkg::len_t'(1);
                  if (last_beat) begin
                     state <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         burst_len <= arlen;
      end
   end

   // stalled beat must not change under the master
   a_rdata_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> $stable(rdata));

   // size fits the bus and a wrap start is aligned to the size
   a_ar_legal: assert property (@(posedge clk) disable iff (rst)
      arvalid |-> arsize <= axi_mem_pkg::MAX_SIZE &&
         (arburst != axi_mem_pkg::BURST_WRAP ||
          (araddr & ((axi_mem_pkg::addr_t'(1) << arsize) - axi_mem_pkg::addr_t'(1))) == '0));

endmodule

`default_nettype wire

// File: axi_write/axi_write_slave.sv
// AXI4 write channel slave
`default_nettype none

module axi_write_slave (
   input  wire                          clk,
   input  wire                          rst,
   // write address
   input  wire axi_mem_pkg::addr_t      awaddr,
   input  wire axi_mem_pkg::len_t       awlen,
   input  wire axi_mem_pkg::size_t      awsize,
   input  wire axi_mem_pkg::burst_t     awburst,
   input  wire                          awvalid,
   output logic                         awready,
   // write data
   input  wire axi_mem_pkg::data_t      wdata,
   input  wire axi_mem_pkg::strb_t      wstrb,
   input  wire                          wlast,
   input  wire                          wvalid,
   output logic                         wready,
   // write response
   output axi_mem_pkg::resp_t           bresp,
   output logic                         bvalid,
   input  wire                          bready,
   // address generator
   output logic                         ag_load,
   output logic                         ag_advance,
   input  wire axi_mem_pkg::addr_t      ag_addr,
   // memory write port
   output logic                         mem_we,
   output axi_mem_pkg::word_idx_t       mem_waddr,
   output axi_mem_pkg::data_t           mem_wdata,
   output axi_mem_pkg::strb_t           mem_wstrb
);

   typedef enum logic [1:0] {
      st_idle,
      st_receive,
      st_respond
   } state_t;

   state_t            state;
   axi_mem_pkg::len_t beat_cnt;
   axi_mem_pkg::len_t burst_len;
   logic              err;        // reserved burst type seen on aw
   logic              aw_fire;
   logic              w_fire;
   logic              last_beat;

   assign aw_fire   = awvalid && awready;
   assign w_fire    = wvalid && wready;
   assign last_beat = beat_cnt == burst_len;

   assign awready = state == st_idle;  // aw waits while a burst runs
   assign wready  = state == st_receive;
   assign bvalid  = state == st_respond;
   assign bresp   = err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;

   // generator takes the aw fields directly at the handshake
   assign ag_load    = aw_fire;
   assign ag_advance = w_fire;

   assign mem_we    = w_fire && !err;
   assign mem_waddr = ag_addr[axi_mem_pkg::WORD_MSB:axi_mem_pkg::WORD_LSB];
   assign mem_wdata = wdata;
   assign mem_wstrb = wstrb;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= st_idle;
         beat_cnt <= '0;
         err      <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (aw_fire) begin
                  state    <= st_receive;
                  beat_cnt <= '0;
                  err      <= awburst == axi_mem_pkg::BURST_RSVD;
               end
            end
            st_receive: begin
               if (w_fire) begin
                  beat_cnt <= beat_cnt + axi_mem_pkg::len_t'(1);
                  if (last_beat) begin
                     state <= st_respond;
                  end
               end
            end
            st_respond: begin
               if (bready) begin
                  state <= st_idle;  // b held until taken
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         burst_len <= awlen;
      end
   end

   // master's wlast has to agree with the length given on aw
   a_wlast: assert property (@(posedge clk) disable iff (rst)
      w_fire |-> wlast == last_beat);

   // size fits the bus, wrap start aligned to size
   a_aw_legal: assert property (@(posedge clk) disable iff (rst)
      awvalid |-> awsize <= axi_mem_pkg::MAX_SIZE &&
         (awburst != axi_mem_pkg::BURST_WRAP ||
          (awaddr & ((axi_mem_pkg::addr_t'(1) << awsize) - axi_mem_pkg::addr_t'(1))) == '0));

endmodule

`default_nettype wire

// File: bench/axi_mem_tb.sv
// AXI4 memory slave testbench
`default_nettype none

module axi_mem_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES    = 5;
   localparam int TOTAL_BEATS     = 46;  // all bursts of all tests
   localparam int CYCLES_PER_BEAT = 20;

   logic clk;
   logic rst;
   axi_mem_pkg::addr_t  araddr;
   axi_mem_pkg::len_t   arlen;
   axi_mem_pkg::size_t  arsize;
   axi_mem_pkg::burst_t arburst;
   logic                arvalid;
   logic                arready;
   axi_mem_pkg::data_t  rdata;
   axi_mem_pkg::resp_t  rresp;
   logic                rlast;
   logic                rvalid;
   logic                rready;
   axi_mem_pkg::addr_t  awaddr;
   axi_mem_pkg::len_t   awlen;
   axi_mem_pkg::size_t  awsize;
   axi_mem_pkg::burst_t awburst;
   logic                awvalid;
   logic                awready;
   axi_mem_pkg::data_t  wdata;
   axi_mem_pkg::strb_t  wstrb;
   logic                wlast;
   logic                wvalid;
   logic                wready;
   axi_mem_pkg::resp_t  bresp;
   logic                bvalid;
   logic                bready;

   axi_mem_pkg::data_t model_mem [axi_mem_pkg::MEM_WORDS];  // reference memory
   axi_mem_pkg::data_t beat_data [256];                     // next write burst
   axi_mem_pkg::strb_t beat_strb [256];
   integer             seed;
   int                 check_count;

   axi_mem_top axi_mem_top_inst (
      .clk(clk), .rst(rst),
      .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
      .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
      .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
      .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready)
   );

   always #5 clk = ~clk;

   // byte address of beat n for 8 byte beats
   function automatic axi_mem_pkg::addr_t beat_addr(input axi_mem_pkg::addr_t start,
         input axi_mem_pkg::len_t len, input axi_mem_pkg::burst_t burst, input int n);
      axi_mem_pkg::addr_t total;
      axi_mem_pkg::addr_t base;
      total = (axi_mem_pkg::addr_t'(len) + 32'd1) * 32'd8;
      base  = (start / total) * total;  // wrap boundary
      case (burst)
         axi_mem_pkg::BURST_FIXED: return start;
         axi_mem_pkg::BURST_WRAP:
            return base + ((start - base + axi_mem_pkg::addr_t'(n) * 32'd8) % total);
         default: return (start & ~32'd7) + axi_mem_pkg::addr_t'(n) * 32'd8;
      endcase
   endfunction

   function automatic axi_mem_pkg::word_idx_t word_of(input axi_mem_pkg::addr_t a);
      return a[12:3];  // wraps into 8 KiB
   endfunction

   function automatic axi_mem_pkg::data_t merge_bytes(input axi_mem_pkg::data_t old_word,
         input axi_mem_pkg::data_t new_word, input axi_mem_pkg::strb_t strb);
      axi_mem_pkg::data_t result;
      result = old_word;
      for (int b = 0; b < 8; b++) begin
         if (strb[b]) begin
            result[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return result;
   endfunction

   task automatic check_equal(input string name, input logic [63:0] expected,
         input logic [63:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("CHECK FAILED at %0d ns: %s expected %h, got %h",
                  $time, name, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // writes beat_data/beat_strb, then checks bresp and updates the model
   task automatic axi_write_burst(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::len_t len,
         input axi_mem_pkg::burst_t burst);
      axi_mem_pkg::resp_t exp_resp;
      axi_mem_pkg::addr_t a;
      exp_resp = (burst == axi_mem_pkg::BURST_RSVD) ? axi_mem_pkg::RESP_SLVERR
                                                    : axi_mem_pkg::RESP_OKAY;
      awaddr  <= addr;
      awlen   <= len;
      awsize  <= 3'd3;
      awburst <= burst;
      awvalid <= 1'b1;
      @(posedge clk);
      while (!awready) @(posedge clk);
      awvalid <= 1'b0;
      for (int i = 0; i <= int'(len); i++) begin
         wdata  <= beat_data[i];
         wstrb  <= beat_strb[i];
         wlast  <= (i == int'(len));
         wvalid <= 1'b1;
         @(posedge clk);
         while (!wready) @(posedge clk);
      end
      wvalid <= 1'b0;
      wlast  <= 1'b0;
      bready <= 1'b1;
      @(posedge clk);
      while (!bvalid) @(posedge clk);
      bready <= 1'b0;
      check_equal("bresp", 64'(exp_resp), 64'(bresp));
      if (burst != axi_mem_pkg::BURST_RSVD) begin  // reserved type writes nothing
         for (int i = 0; i <= int'(len); i++) begin
            a = beat_addr(addr, len, burst, i);
            model_mem[word_of(a)] = merge_bytes(model_mem[word_of(a)], beat_data[i],
                                                beat_strb[i]);
         end
      end
   endtask

   task automatic axi_read_burst(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::len_t len,
         input axi_mem_pkg::burst_t burst, input bit stall);
      axi_mem_pkg::data_t exp_data;
      axi_mem_pkg::resp_t exp_resp;
      int                 wait_cycles;
      int                 beat;
      bit                 err_burst;
      err_burst = burst == axi_mem_pkg::BURST_RSVD;
      exp_resp  = err_burst ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
      araddr  <= addr;
      arlen   <= len;
      arsize  <= 3'd3;
      arburst <= burst;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      @(posedge clk);
      while (!arready) @(posedge clk);
      arvalid <= 1'b0;
      wait_cycles = 0;
      do begin
         @(posedge clk);
         wait_cycles++;
      end while (!rvalid);
      check_equal("rvalid latency", 64'(2), 64'(wait_cycles));
      beat = 0;
      while (beat <= int'(len)) begin
         if (rvalid && rready) begin
            exp_data = err_burst ? '0 : model_mem[word_of(beat_addr(addr, len, burst, beat))];
            check_equal("rdata", exp_data, rdata);
            check_equal("rresp", 64'(exp_resp), 64'(rresp));
            check_equal("rlast", 64'(beat == int'(len)), 64'(rlast));
            beat++;
         end
         if (stall) begin
            rready <= ($random(seed) % 4) != 0;  // about one stall in four
         end
         if (beat <= int'(len)) begin
            @(posedge clk);
         end
      end
      rready <= 1'b0;
   endtask

   task automatic reset_and_single_beat();
      check_equal("arready", 64'(1), 64'(arready));
      check_equal("awready", 64'(1), 64'(awready));
      check_equal("rvalid", 64'(0), 64'(rvalid));
      check_equal("bvalid", 64'(0), 64'(bvalid));
      check_equal("wready", 64'(0), 64'(wready));
      beat_data[0] = {$random(seed), $random(seed)};
      beat_strb[0] = 8'hff;
      axi_write_burst(32'h0000_0040, 8'd0, axi_mem_pkg::BURST_INCR);
      axi_read_burst(32'h0000_0040, 8'd0, axi_mem_pkg::BURST_INCR, 1'b0);
   endtask

   task automatic incr_burst_backpressure();
      for (int i = 0; i < 8; i++) begin
         beat_data[i] = {$random(seed), $random(seed)};
         beat_strb[i] = 8'hff;
      end
      axi_write_burst(32'h0000_0100, 8'd7, axi_mem_pkg::BURST_INCR);
      axi_read_burst(32'h0000_0100, 8'd7, axi_mem_pkg::BURST_INCR, 1'b1);
   endtask

   task automatic byte_strobe_merge();
      beat_data[0] = 64'h0123_4567_89ab_cdef;  // known background
      beat_strb[0] = 8'hff;
      axi_write_burst(32'h0000_0208, 8'd0, axi_mem_pkg::BURST_INCR);
      beat_data[0] = {$random(seed), $random(seed)};
      beat_strb[0] = 8'b1010_0101;
      axi_write_burst(32'h0000_0208, 8'd0, axi_mem_pkg::BURST_INCR);
      axi_read_burst(32'h0000_0208, 8'd0, axi_mem_pkg::BURST_INCR, 1'b0);
   endtask

   task automatic fixed_and_wrap_bursts();
      beat_data[0] = {$random(seed), $random(seed)};
      beat_data[1] = {$random(seed), $random(seed)};
      beat_strb[0] = 8'hff;
      beat_strb[1] = 8'hff;
      axi_write_burst(32'h0000_0300, 8'd1, axi_mem_pkg::BURST_INCR);
      for (int i = 0; i < 4; i++) begin
         beat_data[i] = {$random(seed), $random(seed)};
      end
      beat_strb[0] = 8'h0f;  // later beats win on overlapping lanes
      beat_strb[1] = 8'h3c;
      beat_strb[2] = 8'hf0;
      beat_strb[3] = 8'h81;
      axi_write_burst(32'h0000_0300, 8'd3, axi_mem_pkg::BURST_FIXED);
      // neighbor word must be untouched by the fixed burst
      axi_read_burst(32'h0000_0300, 8'd1, axi_mem_pkg::BURST_INCR, 1'b0);
      for (int i = 0; i < 4; i++) begin
         beat_data[i] = {$random(seed), $random(seed)};
         beat_strb[i] = 8'hff;
      end
      axi_write_burst(32'h0000_0400, 8'd3, axi_mem_pkg::BURST_INCR);
      // word order 3 4 1 2 within the 32 byte block
      axi_read_burst(32'h0000_0410, 8'd3, axi_mem_pkg::BURST_WRAP, 1'b0);
   endtask

   task automatic reserved_burst_type();
      for (int i = 0; i < 2; i++) begin
         beat_data[i] = {$random(seed), $random(seed)};
         beat_strb[i] = 8'hff;
      end
      axi_write_burst(32'h0000_0500, 8'd1, axi_mem_pkg::BURST_INCR);
      beat_data[0] = ~beat_data[0];
      beat_data[1] = ~beat_data[1];
      axi_write_burst(32'h0000_0500, 8'd1, axi_mem_pkg::BURST_RSVD);
      axi_read_burst(32'h0000_0500, 8'd1, axi_mem_pkg::BURST_INCR, 1'b0);
      axi_read_burst(32'h0000_0600, 8'd2, axi_mem_pkg::BURST_RSVD, 1'b0);
   endtask

   initial begin
      seed        = 78606;
      check_count = 0;
      clk         = 1'b0;
      rst         = 1'b1;
      araddr      = '0;
      arlen       = '0;
      arsize      = '0;
      arburst     = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      awaddr      = '0;
      awlen       = '0;
      awsize      = '0;
      awburst     = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wlast       = 1'b0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      reset_and_single_beat();
      incr_burst_backpressure();
      byte_strobe_merge();
      fixed_and_wrap_bursts();
      reserved_burst_type();
      @(posedge clk);
      if (check_count > 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("no checks were executed");
         $display("Done: errors found");
         $fatal(1, "empty run");
      end
   end

   // watchdog with a fixed budget per beat
   initial begin
      repeat (RESET_CYCLES + TOTAL_BEATS * CYCLES_PER_BEAT) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles",
               RESET_CYCLES + TOTAL_BEATS * CYCLES_PER_BEAT);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: common/axi_mem_pkg.sv
// AXI4 memory slave
// shared types and constants
`default_nettype none

package axi_mem_pkg;

   // bus field types
   typedef logic [31:0] addr_t;      // byte address
   typedef logic [63:0] data_t;      // one beat
   typedef logic [7:0]  strb_t;      // byte lanes
   typedef logic [7:0]  len_t;       // beats minus one
   typedef logic [2:0]  size_t;      // log2 bytes per beat
   typedef logic [1:0]  burst_t;
   typedef logic [1:0]  resp_t;

   // storage
   typedef logic [9:0]  word_idx_t;  // word index into the array

   localparam int DATA_BYTES = 8;
   localparam int MEM_WORDS  = 1024;

   // largest legal transfer size, log2 of the bus width in bytes
   localparam int MAX_SIZE = $clog2(DATA_BYTES);

   // address bits that select a word, wraps into the memory size
   localparam int WORD_LSB = $clog2(DATA_BYTES);
   localparam int WORD_MSB = $clog2(DATA_BYTES * MEM_WORDS) - 1;

   // burst codes
   localparam burst_t BURST_FIXED = 2'd0;
   localparam burst_t BURST_INCR  = 2'd1;
   localparam burst_t BURST_WRAP  = 2'd2;
   localparam burst_t BURST_RSVD  = 2'd3;  // reserved, answered with slverr

   // response codes
   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// File: filelist.f
common/axi_mem_pkg.sv
source/burst_addr_gen.sv
source/mem_array.sv
axi_write/axi_write_slave.sv
axi_read/axi_read_slave.sv
source/axi_mem_top.sv
bench/axi_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the AXI memory slave testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module axi_mem_tb -f filelist.f -o axi_mem_sim

# exit status is nonzero when the testbench ends in $fatal
./obj_dir/axi_mem_sim

// File: source/axi_mem_top.sv
// AXI4 memory slave top level
`default_nettype none

module axi_mem_top (
   input  wire                          clk,
   input  wire                          rst,
   input  wire axi_mem_pkg::addr_t      araddr,
   input  wire axi_mem_pkg::len_t       arlen,
   input  wire axi_mem_pkg::size_t      arsize,
   input  wire axi_mem_pkg::burst_t     arburst,
   input  wire                          arvalid,
   output logic                         arready,
   output axi_mem_pkg::data_t           rdata,
   output axi_mem_pkg::resp_t           rresp,
   output logic                         rlast,
   output logic                         rvalid,
   input  wire                          rready,
   input  wire axi_mem_pkg::addr_t      awaddr,
   input  wire axi_mem_pkg::len_t       awlen,
   input  wire axi_mem_pkg::size_t      awsize,
   input  wire axi_mem_pkg::burst_t     awburst,
   input  wire                          awvalid,
   output logic                         awready,
   input  wire axi_mem_pkg::data_t      wdata,
   input  wire axi_mem_pkg::strb_t      wstrb,
   input  wire                          wlast,
   input  wire                          wvalid,
   output logic                         wready,
   output axi_mem_pkg::resp_t           bresp,
   output logic                         bvalid,
   input  wire                          bready
);

   wire                          wr_ag_load;
   wire                          wr_ag_advance;
   wire axi_mem_pkg::addr_t      wr_ag_addr;
   wire                          rd_ag_load;
   wire                          rd_ag_advance;
   wire axi_mem_pkg::addr_t      rd_ag_addr;
   wire axi_mem_pkg::addr_t      rd_ag_next_addr;
   wire                          mem_we;
   wire axi_mem_pkg::word_idx_t  mem_waddr;
   wire axi_mem_pkg::data_t      mem_wdata;
   wire axi_mem_pkg::strb_t      mem_wstrb;
   wire axi_mem_pkg::word_idx_t  mem_raddr;
   wire axi_mem_pkg::data_t      mem_rdata;

   axi_write_slave write_slave (
      .clk(clk), .rst(rst),
      .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
      .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .ag_load(wr_ag_load), .ag_advance(wr_ag_advance), .ag_addr(wr_ag_addr),
      .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb)
   );

   // write side steps only on accepted beats, no lookahead needed
   burst_addr_gen write_ag (
      .clk(clk), .rst(rst), .load(wr_ag_load), .start_addr(awaddr), .size(awsize),
      .len(awlen), .burst(awburst), .advance(wr_ag_advance),
      .addr(wr_ag_addr), .next_addr()
   );

   axi_read_slave read_slave (
      .clk(clk), .rst(rst),
      .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
      .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
      .ag_load(rd_ag_load), .ag_advance(rd_ag_advance), .ag_addr(rd_ag_addr),
      .ag_next_addr(rd_ag_next_addr), .mem_raddr(mem_raddr), .mem_rdata(mem_rdata)
   );

   burst_addr_gen read_ag (
      .clk(clk), .rst(rst), .load(rd_ag_load), .start_addr(araddr), .size(arsize),
      .len(arlen), .burst(arburst), .advance(rd_ag_advance),
      .addr(rd_ag_addr), .next_addr(rd_ag_next_addr)
   );

   mem_array memory (
      .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata), .wstrb(mem_wstrb),
      .raddr(mem_raddr), .rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// File: source/burst_addr_gen.sv
// burst beat address generator
`default_nettype none

module burst_addr_gen (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          load,
   input  wire axi_mem_pkg::addr_t      start_addr,
   input  wire axi_mem_pkg::size_t      size,
   input  wire axi_mem_pkg::len_t       len,
   input  wire axi_mem_pkg::burst_t     burst,
   input  wire                          advance,
   output axi_mem_pkg::addr_t           addr,
   output axi_mem_pkg::addr_t           next_addr
);

   axi_mem_pkg::size_t  cur_size;
   axi_mem_pkg::len_t   cur_len;
   axi_mem_pkg::burst_t cur_burst;
   axi_mem_pkg::addr_t  beat_bytes;
   axi_mem_pkg::addr_t  aligned;
   axi_mem_pkg::addr_t  wrap_mask;

   assign beat_bytes = axi_mem_pkg::addr_t'(1) << cur_size;
   assign aligned    = addr & ~(beat_bytes - axi_mem_pkg::addr_t'(1));

   // block of (len+1) beats, minus one
   assign wrap_mask = ((axi_mem_pkg::addr_t'(cur_len) + axi_mem_pkg::addr_t'(1)) << cur_size)
                      - axi_mem_pkg::addr_t'(1);

   always_comb begin
      case (cur_burst)
         axi_mem_pkg::BURST_INCR: next_addr = aligned + beat_bytes;
         axi_mem_pkg::BURST_WRAP:
            next_addr = (addr & ~wrap_mask) | ((aligned + beat_bytes) & wrap_mask);
         default: next_addr = addr;  // fixed, reserved stays put too
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         addr      <= '0;
         cur_size  <= '0;
         cur_len   <= '0;
         cur_burst <= axi_mem_pkg::BURST_INCR;
      end else if (load) begin
         addr      <= start_addr;
         cur_size  <= size;
         cur_len   <= len;
         cur_burst <= burst;
      end else if (advance) begin
         addr <= next_addr;
      end
   end

   // wrap bursts are only defined for 2, 4, 8 or 16 beats
   a_wrap_len: assert property (@(posedge clk) disable iff (rst)
      load && burst == axi_mem_pkg::BURST_WRAP |-> len inside {8'd1, 8'd3, 8'd7, 8'd15});

endmodule

`default_nettype wire

// File: source/mem_array.sv
// dual-port word memory
// byte strobed write, registered read
`default_nettype none

module mem_array (
   input  wire                           clk,
   input  wire                           we,
   input  wire axi_mem_pkg::word_idx_t   waddr,
   input  wire axi_mem_pkg::data_t       wdata,
   input  wire axi_mem_pkg::strb_t       wstrb,
   input  wire axi_mem_pkg::word_idx_t   raddr,
   output axi_mem_pkg::data_t            rdata
);

   axi_mem_pkg::data_t mem [axi_mem_pkg::MEM_WORDS];

   // write port, only lanes with strobe set
   always_ff @(posedge clk) begin
      if (we) begin
         for (int i = 0; i < axi_mem_pkg::DATA_BYTES; i++) begin
            if (wstrb[i]) begin
               mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
   end

   // read port, sampled every cycle
   // a same-word write in this cycle is not seen yet
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire
